//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := backend_tb
FILELIST  := backend_top.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- backend_top.f
common/backend_pkg.sv
src/arch_regfile.sv
src/alu_unit.sv
rename/rename_map.sv
rename/rename_stage.sv
rob/reorder_buffer.sv
src/backend_top.sv
sim/backend_props.sv
sim/backend_tb.sv

//--- common/backend_pkg.sv
`default_nettype none

package backend_pkg;

  localparam int XLEN      = 32;
  localparam int ARCH_REGS = 32;
  localparam int ROB_DEPTH = 8;
  localparam int IMM_W     = 16;

  localparam int ARCH_IDX_W = $clog2(ARCH_REGS);
  localparam int ROB_IDX_W  = $clog2(ROB_DEPTH);

  typedef logic [XLEN-1:0]       data_t;
  typedef logic [ARCH_IDX_W-1:0] arch_id_t;
  typedef logic [ROB_IDX_W-1:0]  rob_id_t;
  typedef logic [2:0]            alu_op_t;

  // one extra bit so a full buffer is distinct from an empty one
  typedef logic [ROB_IDX_W:0] rob_cnt_t;

  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_SUB = 3'd1;
  localparam alu_op_t OP_AND = 3'd2;
  localparam alu_op_t OP_OR  = 3'd3;
  localparam alu_op_t OP_XOR = 3'd4;
  localparam alu_op_t OP_SLL = 3'd5;

  // use_imm swaps rs2 for the sign-extended immediate
  typedef struct packed {
    alu_op_t          op;
    arch_id_t         rd;
    arch_id_t         rs1;
    arch_id_t         rs2;
    logic [IMM_W-1:0] imm;
    logic             use_imm;
  } inst_pkt_t;

  typedef struct packed {
    alu_op_t op;
    rob_id_t tag;
    data_t   opa;
    data_t   opb;
  } issue_pkt_t;

  // result bus
  typedef struct packed {
    logic    valid;
    rob_id_t tag;
    data_t   data;
  } cdb_t;

  typedef struct packed {
    arch_id_t rd;
    data_t    data;
  } commit_t;

endpackage

`default_nettype wire

//--- rename/rename_map.sv
`timescale 1ns/1ns
`default_nettype none

module rename_map
  import backend_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,

  input  arch_id_t [1:0] raddr_i,
  output logic     [1:0] busy_o,
  output rob_id_t  [1:0] tag_o,

  input  logic           alloc_valid_i,
  input  arch_id_t       alloc_rd_i,
  input  rob_id_t        alloc_tag_i,

  input  logic           retire_valid_i,
  input  arch_id_t       retire_rd_i,
  input  rob_id_t        retire_tag_i
);

  logic    [ARCH_REGS-1:0] busy_q;
  rob_id_t                 tag_q [ARCH_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      // only clear when no younger writer has taken the register since
      if (retire_valid_i && tag_q[retire_rd_i] == retire_tag_i) begin
        busy_q[retire_rd_i] <= 1'b0;
      end
      // the later assignment lets a same-edge allocation win
      if (alloc_valid_i && alloc_rd_i != '0) begin
        busy_q[alloc_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid_i && alloc_rd_i != '0) begin
      tag_q[alloc_rd_i] <= alloc_tag_i;
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      busy_o[i] = busy_q[raddr_i[i]];
      tag_o[i]  = tag_q[raddr_i[i]];
    end
  end

endmodule

`default_nettype wire

//--- rename/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rename_stage
  import backend_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,

  input  logic            pkt_valid_i,
  output logic            pkt_ready_o,
  input  inst_pkt_t       pkt_i,

  output arch_id_t  [1:0] rf_raddr_o,
  input  data_t     [1:0] rf_rdata_i,
  input  logic      [1:0] map_busy_i,
  input  rob_id_t   [1:0] map_tag_i,
  input  logic      [1:0] rob_done_i,
  input  data_t     [1:0] rob_value_i,

  input  logic            alloc_ready_i,
  input  rob_id_t         alloc_tag_i,
  output logic            alloc_valid_o,
  output arch_id_t        alloc_rd_o,

  input  cdb_t            cdb_i,
  output logic            issue_valid_o,
  output issue_pkt_t      issue_o
);

  logic      skid_busy_q;
  inst_pkt_t skid_q;
  logic      sel_valid;
  inst_pkt_t sel_pkt;
  logic      issue;
  logic      [1:0] src_ready;
  data_t     [1:0] src_value;
  data_t     imm_ext;

  assign pkt_ready_o = !skid_busy_q;
  assign sel_valid   = pkt_valid_i | skid_busy_q;
  assign sel_pkt     = skid_busy_q ? skid_q : pkt_i;

  // skid fills whenever something is offered but not issued
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_busy_q <= 1'b0;
    end else begin
      skid_busy_q <= sel_valid && !issue;
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_q <= pkt_i;
    end
  end

  assign rf_raddr_o[0] = sel_pkt.rs1;
  assign rf_raddr_o[1] = sel_pkt.rs2;

  // result bus wins over a finished rob entry, which wins over the register file
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      src_ready[i] = 1'b1;
      src_value[i] = rf_rdata_i[i];
      if (map_busy_i[i]) begin
        src_ready[i] = 1'b0;
        if (cdb_i.valid && cdb_i.tag == map_tag_i[i]) begin
          src_ready[i] = 1'b1;
          src_value[i] = cdb_i.data;
        end else if (rob_done_i[i]) begin
          src_ready[i] = 1'b1;
          src_value[i] = rob_value_i[i];
        end
      end
    end
  end

  assign imm_ext = {{(XLEN-IMM_W){sel_pkt.imm[IMM_W-1]}}, sel_pkt.imm};

  assign issue = sel_valid && alloc_ready_i && src_ready[0] &&
                 (sel_pkt.use_imm || src_ready[1]);

  assign alloc_valid_o = issue;
  assign alloc_rd_o    = sel_pkt.rd;
  assign issue_valid_o = issue;

  always_comb begin
    issue_o.op  = sel_pkt.op;
    issue_o.tag = alloc_tag_i;
    issue_o.opa = src_value[0];
    issue_o.opb = sel_pkt.use_imm ? imm_ext : src_value[1];
  end

endmodule

`default_nettype wire

//--- rob/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer
  import backend_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,

  input  logic           alloc_valid_i,
  input  arch_id_t       alloc_rd_i,
  output logic           alloc_ready_o,
  output rob_id_t        alloc_tag_o,

  input  rob_id_t  [1:0] lookup_tag_i,
  output logic     [1:0] lookup_done_o,
  output data_t    [1:0] lookup_value_o,

  input  cdb_t           cdb_i,

  output logic           rf_we_o,
  output arch_id_t       rf_waddr_o,
  output data_t          rf_wdata_o,

  output logic           retire_valid_o,
  output arch_id_t       retire_rd_o,
  output rob_id_t        retire_tag_o,

  output logic           commit_valid_o,
  input  logic           commit_ready_i,
  output commit_t        commit_o
);

  rob_id_t  head_q;
  rob_id_t  tail_q;
  rob_cnt_t count_q;

  logic     [ROB_DEPTH-1:0] done_q;
  arch_id_t                 rd_q   [ROB_DEPTH];
  data_t                    data_q [ROB_DEPTH];

  logic retire;

  assign alloc_ready_o = count_q != rob_cnt_t'(ROB_DEPTH);
  assign alloc_tag_o   = tail_q;

  // head done implies count is nonzero
  assign commit_valid_o = done_q[head_q];
  assign commit_o.rd    = rd_q[head_q];
  assign commit_o.data  = data_q[head_q];
  assign retire         = commit_valid_o && commit_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc_valid_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (cdb_i.valid) begin
        done_q[cdb_i.tag] <= 1'b1;
      end
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      count_q <= count_q + rob_cnt_t'(alloc_valid_i) - rob_cnt_t'(retire);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_i.valid) begin
      data_q[cdb_i.tag] <= cdb_i.data;
    end
  end

  // operand lookup for busy sources
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      lookup_done_o[i]  = done_q[lookup_tag_i[i]];
      lookup_value_o[i] = data_q[lookup_tag_i[i]];
    end
  end

  // retire writes the register file and frees the rename entry together
  assign rf_we_o        = retire && rd_q[head_q] != '0;
  assign rf_waddr_o     = rd_q[head_q];
  assign rf_wdata_o     = data_q[head_q];
  assign retire_valid_o = retire;
  assign retire_rd_o    = rd_q[head_q];
  assign retire_tag_o   = head_q;

endmodule

`default_nettype wire

//--- sim/backend_props.sv
`timescale 1ns/1ns
`default_nettype none

module backend_props
  import backend_pkg::*;
(
  input wire      clk,
  input wire      rst_n,
  input rob_cnt_t rob_count,
  input logic     commit_valid,
  input logic     commit_ready,
  input commit_t  commit,
  input logic     alloc_valid,
  input logic     alloc_ready,
  input logic     pkt_valid,
  input logic     pkt_ready,
  input logic     issue_valid
);

  // packets accepted on the input port but not yet issued
  logic [1:0] pending_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + 2'(pkt_valid && pkt_ready) - 2'(issue_valid);
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    rob_count <= rob_cnt_t'(ROB_DEPTH))
    else $error("reorder buffer count exceeds its depth");

  a_commit_stable: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit))
    else $error("commit output changed while waiting for ready");

  a_alloc_gated: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_valid |-> alloc_ready)
    else $error("allocation requested with no free tag");

  a_skid_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pending_q <= 2'd1 && pkt_ready == (pending_q == 2'd0))
    else $error("pkt_ready_o does not match the packets held in the skid buffer");

endmodule

bind reorder_buffer backend_props i_rob_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .rob_count    (count_q),
  .commit_valid (commit_valid_o),
  .commit_ready (commit_ready_i),
  .commit       (commit_o),
  .alloc_valid  (alloc_valid_i),
  .alloc_ready  (alloc_ready_o),
  .pkt_valid    (1'b0),
  .pkt_ready    (1'b1),
  .issue_valid  (1'b0)
);

bind rename_stage backend_props i_rename_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .rob_count    (rob_cnt_t'(0)),
  .commit_valid (1'b0),
  .commit_ready (1'b1),
  .commit       (commit_t'(0)),
  .alloc_valid  (alloc_valid_o),
  .alloc_ready  (alloc_ready_i),
  .pkt_valid    (pkt_valid_i),
  .pkt_ready    (pkt_ready_o),
  .issue_valid  (issue_valid_o)
);

`default_nettype wire

//--- sim/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb
  import backend_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 16;
  localparam int SEED            = 80;
  localparam int CYCLES_PER_INST = 20;

  typedef struct {
    string name;
    int    first;
    int    len;
    int    hold;
    bit    rand_ready;
  } test_t;

  logic      clk;
  logic      rst_n;
  logic      pkt_valid_i;
  logic      pkt_ready_o;
  inst_pkt_t pkt_i;
  logic      commit_valid_o;
  logic      commit_ready_i;
  commit_t   commit_o;

  inst_pkt_t   prog [$];
  test_t       tests [4];
  int          n_tests;
  commit_t     exp_q [$];
  data_t       ref_regs [ARCH_REGS];
  string       cur_name;
  int unsigned in_seed;
  int unsigned out_seed;
  int          hold_left;
  bit          rand_ready;
  bit          saw_stall;
  int          errors;
  int          test_errors;
  int          failed_tests;
  int          commits;
  longint      limit_ns;

  backend_top i_backend_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .pkt_valid_i    (pkt_valid_i),
    .pkt_ready_o    (pkt_ready_o),
    .pkt_i          (pkt_i),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_o       (commit_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // separate streams so input and output randomness stay independent
  function automatic int unsigned stim_rand();
    in_seed = lcg_step(in_seed);
    return in_seed >> 16;
  endfunction

  function automatic int unsigned ready_rand();
    out_seed = lcg_step(out_seed);
    return out_seed >> 16;
  endfunction

  function automatic data_t alu_ref(input alu_op_t op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic inst_pkt_t imm_op(input alu_op_t op, input arch_id_t rd,
                                       input arch_id_t rs1, input logic [IMM_W-1:0] imm);
    return '{op: op, rd: rd, rs1: rs1, rs2: '0, imm: imm, use_imm: 1'b1};
  endfunction

  function automatic inst_pkt_t reg_op(input alu_op_t op, input arch_id_t rd,
                                       input arch_id_t rs1, input arch_id_t rs2);
    return '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: '0, use_imm: 1'b0};
  endfunction

  function automatic void add_test(input string name, input int hold, input bit rnd);
    tests[n_tests].name       = name;
    tests[n_tests].first      = prog.size();
    tests[n_tests].len        = 0;
    tests[n_tests].hold       = hold;
    tests[n_tests].rand_ready = rnd;
    n_tests++;
  endfunction

  function automatic void emit(input inst_pkt_t p);
    prog.push_back(p);
    tests[n_tests-1].len++;
  endfunction

  task automatic build_tests();
    inst_pkt_t p;
    add_test("independent", 0, 1'b0);
    emit(imm_op(OP_ADD, 5'd1, 5'd0, 16'd100));
    emit(imm_op(OP_ADD, 5'd2, 5'd0, 16'hfffd));
    emit(imm_op(OP_OR,  5'd3, 5'd0, 16'h0f0f));
    emit(imm_op(OP_XOR, 5'd4, 5'd0, 16'h8000));
    emit(imm_op(OP_ADD, 5'd5, 5'd0, 16'h7ff0));
    emit(reg_op(OP_ADD, 5'd6, 5'd1, 5'd2));
    emit(reg_op(OP_SUB, 5'd7, 5'd3, 5'd4));
    emit(reg_op(OP_AND, 5'd8, 5'd4, 5'd2));
    emit(reg_op(OP_OR,  5'd9, 5'd1, 5'd5));
    emit(reg_op(OP_SLL, 5'd10, 5'd3, 5'd1));
    // each one reads the previous result
    add_test("chain", 0, 1'b0);
    emit(imm_op(OP_ADD, 5'd11, 5'd0, 16'd1));
    emit(imm_op(OP_SLL, 5'd11, 5'd11, 16'd4));
    emit(reg_op(OP_ADD, 5'd11, 5'd11, 5'd11));
    emit(reg_op(OP_SUB, 5'd12, 5'd11, 5'd1));
    emit(reg_op(OP_XOR, 5'd11, 5'd12, 5'd11));
    emit(imm_op(OP_ADD, 5'd12, 5'd11, 16'hfffb));
    emit(reg_op(OP_AND, 5'd13, 5'd12, 5'd11));
    emit(imm_op(OP_SLL, 5'd13, 5'd13, 16'd2));
    add_test("zero_and_rewrite", 0, 1'b1);
    emit(imm_op(OP_ADD, 5'd0, 5'd0, 16'd55));
    emit(reg_op(OP_ADD, 5'd14, 5'd0, 5'd0));
    emit(imm_op(OP_ADD, 5'd15, 5'd0, 16'd7));
    emit(imm_op(OP_ADD, 5'd15, 5'd15, 16'd1));
    emit(imm_op(OP_ADD, 5'd15, 5'd15, 16'd1));
    emit(reg_op(OP_OR,  5'd16, 5'd15, 5'd0));
    emit(imm_op(OP_ADD, 5'd0, 5'd15, 16'd5));
    emit(reg_op(OP_ADD, 5'd17, 5'd0, 5'd15));
    // long commit stall first, then random ready
    add_test("backpressure", 40, 1'b1);
    for (int i = 0; i < 24; i++) begin
      p.op      = alu_op_t'(stim_rand() % 6);
      p.rd      = arch_id_t'(stim_rand() % 8);
      p.rs1     = arch_id_t'(stim_rand() % 8);
      p.rs2     = arch_id_t'(stim_rand() % 8);
      p.imm     = IMM_W'(stim_rand());
      p.use_imm = (stim_rand() % 2) != 0;
      emit(p);
    end
  endtask

  // in-order model run on each accepted packet
  task automatic ref_exec(input inst_pkt_t p);
    data_t   a;
    data_t   b;
    commit_t c;
    a = ref_regs[p.rs1];
    b = p.use_imm ? {{(XLEN-IMM_W){p.imm[IMM_W-1]}}, p.imm} : ref_regs[p.rs2];
    c.rd   = p.rd;
    c.data = alu_ref(p.op, a, b);
    exp_q.push_back(c);
    if (p.rd != '0) begin
      ref_regs[p.rd] = c.data;
    end
  endtask

  initial begin
    commit_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      if (hold_left > 0) begin
        commit_ready_i <= 1'b0;
        hold_left--;
      end else if (rand_ready) begin
        commit_ready_i <= (ready_rand() % 3) != 0;
      end else begin
        commit_ready_i <= 1'b1;
      end
    end
  end

  // sampled mid-cycle ahead of the rising edge that transfers
  always @(negedge clk) begin : commit_monitor
    commit_t exp;
    if (rst_n && !pkt_ready_o) begin
      saw_stall = 1'b1;
    end
    if (rst_n && commit_valid_o && commit_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: commit of rd %0d seen with no instruction outstanding",
                 cur_name, commit_o.rd);
        errors++;
        test_errors++;
      end else begin
        exp = exp_q.pop_front();
        commits++;
        assert (commit_o == exp) else begin
          $display("error %s: expected rd %0d data %08h, actual rd %0d data %08h",
                   cur_name, exp.rd, exp.data, commit_o.rd, commit_o.data);
          errors++;
          test_errors++;
        end
      end
    end
  end

  task automatic run_test(input int t);
    int k;
    bit offered;
    cur_name    = tests[t].name;
    test_errors = 0;
    saw_stall   = 1'b0;
    hold_left   = tests[t].hold;
    rand_ready  = tests[t].rand_ready;
    k       = 0;
    offered = 1'b0;
    while (k < tests[t].len) begin
      @(posedge clk);
      if (!offered) begin
        // roughly one cycle in four is left idle
        if (stim_rand() % 4 != 0) begin
          pkt_i       <= prog[tests[t].first + k];
          pkt_valid_i <= 1'b1;
          offered = 1'b1;
        end else begin
          pkt_valid_i <= 1'b0;
        end
      end
      @(negedge clk);
      if (offered && pkt_ready_o) begin
        ref_exec(prog[tests[t].first + k]);
        k++;
        offered = 1'b0;
      end
    end
    @(posedge clk);
    pkt_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    if (tests[t].hold > 0) begin
      assert (saw_stall) else begin
        $display("%s: pkt_ready_o never went low while commits were stalled", cur_name);
        errors++;
        test_errors++;
      end
    end
    rand_ready = 1'b0;
    // idle stretch so a repeated retire of the last entry still shows up
    repeat (ROB_DEPTH) @(negedge clk);
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("%s: %0d instructions, %0d errors", cur_name, tests[t].len, test_errors);
  endtask

  initial begin
    int hold_total;
    rst_n        = 1'b0;
    pkt_valid_i  = 1'b0;
    pkt_i        = '0;
    in_seed      = SEED;
    out_seed     = lcg_step(SEED);
    hold_left    = 0;
    rand_ready   = 1'b0;
    saw_stall    = 1'b0;
    n_tests      = 0;
    errors       = 0;
    test_errors  = 0;
    failed_tests = 0;
    commits      = 0;
    hold_total   = 0;
    for (int r = 0; r < ARCH_REGS; r++) begin
      ref_regs[r] = '0;
    end
    build_tests();
    for (int t = 0; t < n_tests; t++) begin
      hold_total += tests[t].hold + ROB_DEPTH;
    end
    limit_ns = longint'(RESET_CYCLES + hold_total + CYCLES_PER_INST * prog.size() + 200)
               * CLK_PERIOD;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    cur_name = "reset";
    assert (pkt_ready_o === 1'b1 && commit_valid_o === 1'b0) else begin
      $display("error reset: expected ready 1 valid 0, actual ready %b valid %b",
               pkt_ready_o, commit_valid_o);
      errors++;
      failed_tests++;
    end
    $display("reset: idle state checked, %0d errors", errors);

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end

    $display("%0d tests run, %0d with errors, %0d commits checked, %0d errors",
             n_tests + 1, failed_tests, commits, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit
  import backend_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  logic       issue_valid_i,
  input  issue_pkt_t issue_i,
  output cdb_t       cdb_o
);

  data_t   result;
  logic    valid_q;
  rob_id_t tag_q;
  data_t   data_q;

  always_comb begin
    case (issue_i.op)
      OP_ADD:  result = issue_i.opa + issue_i.opb;
      OP_SUB:  result = issue_i.opa - issue_i.opb;
      OP_AND:  result = issue_i.opa & issue_i.opb;
      OP_OR:   result = issue_i.opa | issue_i.opb;
      OP_XOR:  result = issue_i.opa ^ issue_i.opb;
      // shift amount from the low five bits
      OP_SLL:  result = issue_i.opa << issue_i.opb[4:0];
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i) begin
      tag_q  <= issue_i.tag;
      data_q <= result;
    end
  end

  // broadcast one cycle after issue
  assign cdb_o.valid = valid_q;
  assign cdb_o.tag   = tag_q;
  assign cdb_o.data  = data_q;

endmodule

`default_nettype wire

//--- src/arch_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module arch_regfile
  import backend_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  arch_id_t [1:0] raddr_i,
  output data_t    [1:0] rdata_o,
  input  logic           we_i,
  input  arch_id_t       waddr_i,
  input  data_t          wdata_i
);

  data_t regs_q [ARCH_REGS];
  logic  wr_en;

  // x0 is never written, so it holds its reset value
  assign wr_en = we_i && waddr_i != '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // write-through forwarding
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rdata_o[i] = (wr_en && waddr_i == raddr_i[i]) ? wdata_i : regs_q[raddr_i[i]];
    end
  end

endmodule

`default_nettype wire

//--- src/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top
  import backend_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,

  input  logic      pkt_valid_i,
  output logic      pkt_ready_o,
  input  inst_pkt_t pkt_i,

  output logic      commit_valid_o,
  input  logic      commit_ready_i,
  output commit_t   commit_o
);

  arch_id_t [1:0] rf_raddr;
  data_t    [1:0] rf_rdata;
  logic     [1:0] map_busy;
  rob_id_t  [1:0] map_tag;
  logic     [1:0] rob_done;
  data_t    [1:0] rob_value;

  logic       alloc_ready;
  rob_id_t    alloc_tag;
  logic       alloc_valid;
  arch_id_t   alloc_rd;
  logic       issue_valid;
  issue_pkt_t issue_pkt;
  cdb_t       cdb;

  logic     rf_we;
  arch_id_t rf_waddr;
  data_t    rf_wdata;
  logic     retire_valid;
  arch_id_t retire_rd;
  rob_id_t  retire_tag;

  rename_stage i_rename_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkt_valid_i   (pkt_valid_i),
    .pkt_ready_o   (pkt_ready_o),
    .pkt_i         (pkt_i),
    .rf_raddr_o    (rf_raddr),
    .rf_rdata_i    (rf_rdata),
    .map_busy_i    (map_busy),
    .map_tag_i     (map_tag),
    .rob_done_i    (rob_done),
    .rob_value_i   (rob_value),
    .alloc_ready_i (alloc_ready),
    .alloc_tag_i   (alloc_tag),
    .alloc_valid_o (alloc_valid),
    .alloc_rd_o    (alloc_rd),
    .cdb_i         (cdb),
    .issue_valid_o (issue_valid),
    .issue_o       (issue_pkt)
  );

  rename_map i_rename_map (
    .clk            (clk),
    .rst_n          (rst_n),
    .raddr_i        (rf_raddr),
    .busy_o         (map_busy),
    .tag_o          (map_tag),
    .alloc_valid_i  (alloc_valid),
    .alloc_rd_i     (alloc_rd),
    .alloc_tag_i    (alloc_tag),
    .retire_valid_i (retire_valid),
    .retire_rd_i    (retire_rd),
    .retire_tag_i   (retire_tag)
  );

  arch_regfile i_arch_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  // lookups are addressed straight from the rename table tags
  reorder_buffer i_reorder_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .alloc_valid_i  (alloc_valid),
    .alloc_rd_i     (alloc_rd),
    .alloc_ready_o  (alloc_ready),
    .alloc_tag_o    (alloc_tag),
    .lookup_tag_i   (map_tag),
    .lookup_done_o  (rob_done),
    .lookup_value_o (rob_value),
    .cdb_i          (cdb),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid),
    .retire_rd_o    (retire_rd),
    .retire_tag_o   (retire_tag),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_o       (commit_o)
  );

  alu_unit i_alu_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid),
    .issue_i       (issue_pkt),
    .cdb_o         (cdb)
  );

endmodule

`default_nettype wire
